// ==== hdl/fixp_pkg.sv ====
package fixp_pkg;

	////////////////////////////////////////
	// Fixed-point formats of the datapath
	////////////////////////////////////////

	// Pixel width on both sides of the layer
	localparam int PIX_W = 16;

	// Signed weights in Q1.14
	localparam int W_W = 16;
	localparam int FRAC_BITS = 14;

	// Signed accumulator
	// Biases use the same format
	localparam int ACC_W = 32;

	////////////////////////////////////////
	// Requantization
	////////////////////////////////////////

	// Top accumulator bit kept on the way back to pixel format
	localparam int OUT_MSB = 28;

	// Kept slice ACC[OUT_MSB:FRAC_BITS]
	// A zero goes above it to fill PIX_W
	localparam int RQ_W = OUT_MSB - FRAC_BITS + 1;

endpackage

// ==== hdl/conv_pkg.sv ====
package conv_pkg;

	////////////////////////////////////////
	// Layer geometry
	////////////////////////////////////////

	localparam int CH_IN = 4;
	// One MAC lane per output channel
	localparam int CH_OUT = 8;
	localparam int KERNEL_DIM = 3;
	// Every input channel of every kernel position
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CH_IN;
	localparam int OUT_SIDE = 4;
	localparam int OUT_PIXELS = OUT_SIDE * OUT_SIDE;

	// Tap counter and ROM address
	localparam int TAP_W = $clog2(TAPS);
	localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(TAPS - 1);
	// Window counter runs up to OUT_PIXELS
	localparam int PIX_CNT_W = $clog2(OUT_PIXELS + 1);
	localparam logic [PIX_CNT_W-1:0] LAST_PIX = PIX_CNT_W'(OUT_PIXELS - 1);

	////////////////////////////////////////
	// Constant tables
	////////////////////////////////////////

	// Weight of channel c at tap k
	//   (((W_MUL_C*c + W_MUL_K*k) mod W_MOD) - W_OFS) * 2**W_SHIFT
	localparam int W_MUL_C = 7;
	localparam int W_MUL_K = 3;
	localparam int W_MOD = 31;
	localparam int W_OFS = 15;
	localparam int W_SHIFT = 9;

	// Bias of channel c
	//   (c - B_OFS) * 2**B_SHIFT
	localparam int B_OFS = 3;
	localparam int B_SHIFT = 20;

endpackage

// ==== hdl/weight_rom.sv ====
module weight_rom (
	input  logic                                         clk,
	input  logic [conv_pkg::TAP_W-1:0]                   tap_addr,
	output logic [conv_pkg::CH_OUT*fixp_pkg::W_W-1:0]   weight_row
);

	// One row per tap
	// Channel 0 sits in the low bits
	typedef logic [conv_pkg::CH_OUT*fixp_pkg::W_W-1:0] row_t;
	typedef row_t table_t [conv_pkg::TAPS];

	table_t rom_table;

	// Weight of lane c at tap k
	function automatic logic [fixp_pkg::W_W-1:0] weight_of(input int c, input int k);
		int v;
		v = (conv_pkg::W_MUL_C * c + conv_pkg::W_MUL_K * k) % conv_pkg::W_MOD;
		v = (v - conv_pkg::W_OFS) * (2 ** conv_pkg::W_SHIFT);
		return v[fixp_pkg::W_W-1:0];
	endfunction

	// Whole table in one go
	function automatic table_t build_table();
		table_t t;
		for (int k = 0; k < conv_pkg::TAPS; k++) begin
			for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
				t[k][c*fixp_pkg::W_W +: fixp_pkg::W_W] = weight_of(c, k);
			end
		end
		return t;
	endfunction

	////////////////////////////////////////
	// Table contents and read port
	////////////////////////////////////////

	// Constant at elaboration
	assign rom_table = build_table();

	// Registered read
	// Row is out one cycle after the address
	always_ff @(posedge clk) begin
		weight_row <= rom_table[tap_addr];
	end

endmodule

// ==== hdl/bias_table.sv ====
module bias_table (
	output logic [conv_pkg::CH_OUT*fixp_pkg::ACC_W-1:0] bias_row
);

	// Per-channel bias of the layer
	// Sits next to the MAC array and feeds its bias adders

	// Bias of lane c in accumulator format
	function automatic logic [fixp_pkg::ACC_W-1:0] bias_of(input int c);
		int v;
		v = (c - conv_pkg::B_OFS) * (2 ** conv_pkg::B_SHIFT);
		return v[fixp_pkg::ACC_W-1:0];
	endfunction

	////////////////////////////////////////
	// Bias row
	////////////////////////////////////////

	// Lower lanes get negative biases
	// Upper lanes positive
	always_comb begin
		for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
			// Channel 0 lowest
			bias_row[c*fixp_pkg::ACC_W +: fixp_pkg::ACC_W] = bias_of(c);
		end
	end

endmodule

// ==== hdl/tap_sequencer.sv ====
module tap_sequencer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        en,
	input  logic                        ram_feedback,
	output logic [conv_pkg::TAP_W-1:0]  tap_addr,
	output logic                        tap_en,
	output logic                        acc_clr,
	output logic                        acc_done,
	output logic                        finish
);

	logic                           en_ok;
	logic                           en_d1;
	logic [conv_pkg::TAP_W-1:0]     tap_cnt;
	logic [conv_pkg::PIX_CNT_W-1:0] pix_cnt;
	logic                           first_tap;
	logic                           last_tap;
	logic                           closing;
	logic                           tap_en_p2;
	logic                           clr_p2;
	logic                           done_p2;
	logic                           done_p3;
	logic                           layer_end;
	logic                           layer_done;
	logic                           fb_seen;

	////////////////////////////////////////
	// Pixel intake
	////////////////////////////////////////

	// Position of the pixel now in the en register
	assign first_tap = en_d1 && (tap_cnt == '0);
	assign last_tap = en_d1 && (tap_cnt == conv_pkg::LAST_TAP);

	// Last tap of the last window
	assign closing = last_tap && (pix_cnt == conv_pkg::LAST_PIX);

	// No more pixels once the final window is complete
	assign en_ok = en && !layer_end && !closing;

	always_ff @(posedge clk) begin
		if (rst) begin
			en_d1 <= 1'b0;
		end else begin
			en_d1 <= en_ok;
		end
	end

	// Counts consumed taps and wraps on the window end
	always_ff @(posedge clk) begin
		if (rst) begin
			tap_cnt <= '0;
		end else if (last_tap) begin
			tap_cnt <= '0;
		end else if (en_d1) begin
			tap_cnt <= tap_cnt + 1'b1;
		end
	end

	// ROM reads the current tap on the next edge
	assign tap_addr = tap_cnt;

	////////////////////////////////////////
	// Control delays to the MAC lanes
	////////////////////////////////////////

	// Enable and clear meet the kernel and pixel registers
	// Done trails by one so the last product is already summed
	always_ff @(posedge clk) begin
		if (rst) begin
			tap_en_p2 <= 1'b0;
			tap_en    <= 1'b0;
			clr_p2    <= 1'b0;
			acc_clr   <= 1'b0;
			done_p2   <= 1'b0;
			done_p3   <= 1'b0;
			acc_done  <= 1'b0;
		end else begin
			tap_en_p2 <= en_d1;
			tap_en    <= tap_en_p2;
			clr_p2    <= first_tap;
			acc_clr   <= clr_p2;
			done_p2   <= last_tap;
			done_p3   <= done_p2;
			acc_done  <= done_p3;
		end
	end

	////////////////////////////////////////
	// Layer end and finish
	////////////////////////////////////////

	// Window count
	always_ff @(posedge clk) begin
		if (rst) begin
			pix_cnt   <= '0;
			layer_end <= 1'b0;
		end else if (last_tap) begin
			pix_cnt <= pix_cnt + 1'b1;
			if (closing) begin
				layer_end <= 1'b1;
			end
		end
	end

	// Finish follows the last sample by one cycle
	// First feedback pulse drops it for good
	always_ff @(posedge clk) begin
		if (rst) begin
			layer_done <= 1'b0;
			fb_seen    <= 1'b0;
			finish     <= 1'b0;
		end else begin
			if (acc_done && layer_end) begin
				layer_done <= 1'b1;
			end
			if (ram_feedback) begin
				fb_seen <= 1'b1;
			end
			finish <= layer_done && !fb_seen && !ram_feedback;
		end
	end

endmodule

// ==== hdl/mac_unit.sv ====
module mac_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        en,
	input  logic                        clr,
	input  logic [fixp_pkg::PIX_W-1:0]  pix,
	input  logic [fixp_pkg::W_W-1:0]    ker,
	output logic [fixp_pkg::ACC_W-1:0]  sum
);

	logic signed [fixp_pkg::PIX_W+fixp_pkg::W_W-1:0] prod;
	logic signed [fixp_pkg::ACC_W-1:0]               prod_ext;

	// Signed pixel times signed weight
	assign prod = $signed(pix) * $signed(ker);

	// Sign extension into the accumulator
	assign prod_ext = prod;

	////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////

	// Clear marks the first tap of a window
	// Its product replaces the old sum
	always_ff @(posedge clk) begin
		if (rst) begin
			sum <= '0;
		end else if (en) begin
			if (clr) begin
				sum <= prod_ext;
			end else begin
				// Running sum of the window
				sum <= sum + prod_ext;
			end
		end
	end

endmodule

// ==== hdl/mac_array.sv ====
module mac_array (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic [fixp_pkg::PIX_W-1:0]                    ifm,
	input  logic [conv_pkg::CH_OUT*fixp_pkg::W_W-1:0]     weight_row,
	input  logic [conv_pkg::CH_OUT*fixp_pkg::ACC_W-1:0]   bias_row,
	input  logic                                          tap_en,
	input  logic                                          acc_clr,
	input  logic                                          acc_done,
	output logic [conv_pkg::CH_OUT*fixp_pkg::PIX_W-1:0]   ofm,
	output logic                                          sample
);

	logic [fixp_pkg::PIX_W-1:0]                   pix_in;
	logic [fixp_pkg::PIX_W-1:0]                   pix_d;
	logic [fixp_pkg::PIX_W-1:0]                   pix_mac;
	logic [conv_pkg::CH_OUT*fixp_pkg::W_W-1:0]    ker_mac;
	logic [conv_pkg::CH_OUT*fixp_pkg::ACC_W-1:0]  sum_row;
	logic [conv_pkg::CH_OUT*fixp_pkg::ACC_W-1:0]  biased_row;

	////////////////////////////////////////
	// Operand pipeline
	////////////////////////////////////////

	// Pixel taken with its en edge
	// Then delayed to meet the registered ROM row
	always_ff @(posedge clk) begin
		pix_in  <= ifm;
		pix_d   <= pix_in;
		pix_mac <= pix_d;
		ker_mac <= weight_row;
	end

	// One lane per output channel
	for (genvar c = 0; c < conv_pkg::CH_OUT; c++) begin : g_lane
		mac_unit u_mac_unit (
			.clk (clk),
			.rst (rst),
			.en  (tap_en),
			.clr (acc_clr),
			.pix (pix_mac),
			.ker (ker_mac[c*fixp_pkg::W_W +: fixp_pkg::W_W]),
			.sum (sum_row[c*fixp_pkg::ACC_W +: fixp_pkg::ACC_W])
		);
	end

	////////////////////////////////////////
	// Bias, ReLU and requantization
	////////////////////////////////////////

	always_comb begin
		for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
			biased_row[c*fixp_pkg::ACC_W +: fixp_pkg::ACC_W] =
				sum_row[c*fixp_pkg::ACC_W +: fixp_pkg::ACC_W] +
				bias_row[c*fixp_pkg::ACC_W +: fixp_pkg::ACC_W];
		end
	end

	// Sum is still the closed window while the next one starts
	// ofm holds until the next done
	always_ff @(posedge clk) begin
		if (rst) begin
			ofm    <= '0;
			sample <= 1'b0;
		end else begin
			sample <= acc_done;
			if (acc_done) begin
				for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
					// Negative sums clamp to zero
					if (biased_row[c*fixp_pkg::ACC_W + fixp_pkg::ACC_W - 1]) begin
						ofm[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W] <= '0;
					end else begin
						ofm[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W] <=
							{{(fixp_pkg::PIX_W - fixp_pkg::RQ_W){1'b0}},
							biased_row[c*fixp_pkg::ACC_W + fixp_pkg::FRAC_BITS +: fixp_pkg::RQ_W]};
					end
				end
			end
		end
	end

endmodule

// ==== hdl/conv_layer.sv ====
module conv_layer (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          en,
	input  logic [fixp_pkg::PIX_W-1:0]                    ifm,
	input  logic                                          ram_feedback,
	output logic [conv_pkg::CH_OUT*fixp_pkg::PIX_W-1:0]   ofm,
	output logic                                          sample,
	output logic                                          finish
);

	logic [conv_pkg::TAP_W-1:0]                   tap_addr;
	logic [conv_pkg::CH_OUT*fixp_pkg::W_W-1:0]    weight_row;
	logic [conv_pkg::CH_OUT*fixp_pkg::ACC_W-1:0]  bias_row;
	logic                                         tap_en;
	logic                                         acc_clr;
	logic                                         acc_done;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	tap_sequencer u_tap_sequencer (
		.clk          (clk),
		.rst          (rst),
		.en           (en),
		.ram_feedback (ram_feedback),
		.tap_addr     (tap_addr),
		.tap_en       (tap_en),
		.acc_clr      (acc_clr),
		.acc_done     (acc_done),
		.finish       (finish)
	);

	// Weights by tap
	weight_rom u_weight_rom (
		.clk        (clk),
		.tap_addr   (tap_addr),
		.weight_row (weight_row)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	// Biases for the lanes
	bias_table u_bias_table (
		.bias_row (bias_row)
	);

	mac_array u_mac_array (
		.clk        (clk),
		.rst        (rst),
		.ifm        (ifm),
		.weight_row (weight_row),
		.bias_row   (bias_row),
		.tap_en     (tap_en),
		.acc_clr    (acc_clr),
		.acc_done   (acc_done),
		.ofm        (ofm),
		.sample     (sample)
	);

endmodule

// ==== bench/conv_layer_properties.sv ====
module conv_layer_properties (
	input logic clk,
	input logic rst,
	input logic tap_en,
	input logic acc_clr,
	input logic acc_done,
	input logic finish
);

	// Failed assertions, read back by the testbench
	int fail_cnt = 0;

	// Taps summed since the last clear
	int taps_seen;

	always_ff @(posedge clk) begin
		if (rst) begin
			taps_seen <= 0;
		end else if (tap_en) begin
			if (acc_clr) begin
				taps_seen <= 1;
			end else begin
				taps_seen <= taps_seen + 1;
			end
		end
	end

	////////////////////////////////////////
	// Sequencer timing
	////////////////////////////////////////

	// Strobes and finish low right after reset
	// acc_done here is sample one cycle early
	assert property (@(posedge clk) rst |=> !finish && !acc_done && !acc_clr && !tap_en)
		else begin
			fail_cnt++;
			$error("control output high on the cycle after reset");
		end

	// A clear only opens a window, never cuts one short
	assert property (@(posedge clk) disable iff (rst)
		acc_clr |-> (taps_seen == 0 || taps_seen == conv_pkg::TAPS))
		else begin
			fail_cnt++;
			$error("acc_clr in the middle of a window");
		end

	// Done only once a full window of taps is summed
	// Holds also when the next clear lands on the same cycle
	assert property (@(posedge clk) disable iff (rst) acc_done |-> taps_seen == conv_pkg::TAPS)
		else begin
			fail_cnt++;
			$error("acc_done without a full window of taps summed");
		end

	// One done per window, so sample never lasts two cycles
	assert property (@(posedge clk) disable iff (rst) acc_done |=> !acc_done)
		else begin
			fail_cnt++;
			$error("acc_done high on two consecutive cycles");
		end

endmodule

bind tap_sequencer conv_layer_properties u_conv_layer_properties (
	.clk      (clk),
	.rst      (rst),
	.tap_en   (tap_en),
	.acc_clr  (acc_clr),
	.acc_done (acc_done),
	.finish   (finish)
);

// ==== bench/conv_layer_checker.sv ====
module conv_layer_checker (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         en,
	input  logic [fixp_pkg::PIX_W-1:0]                   ifm,
	input  logic                                         ram_feedback,
	input  logic [conv_pkg::CH_OUT*fixp_pkg::PIX_W-1:0]  ofm,
	input  logic                                         sample,
	input  logic                                         finish,
	output int                                           err_cnt,
	output int                                           sample_cnt
);

	typedef logic [fixp_pkg::PIX_W-1:0] window_t [conv_pkg::TAPS];
	typedef logic [conv_pkg::CH_OUT*fixp_pkg::PIX_W-1:0] row_t;

	window_t win;
	int      tap_idx;
	int      consumed;
	int      samples;
	int      errs = 0;
	longint  cyc = 0;
	longint  end_cyc;
	longint  end_cyc_q [$];
	row_t    exp_row;
	row_t    held_row;
	row_t    exp_q [$];
	logic    done_seen;
	logic    fb_seen;
	logic    exp_fin;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// One output channel of a closed window
	function automatic logic [fixp_pkg::PIX_W-1:0] ref_channel(input int c, input window_t w);
		longint acc;
		longint wt;
		logic [fixp_pkg::ACC_W-1:0] acc_low;
		acc = 0;
		for (int k = 0; k < conv_pkg::TAPS; k++) begin
			// Weight rule (((7c + 3k) mod 31) - 15) * 512
			wt = longint'((((7 * c + 3 * k) % 31) - 15) * 512);
			acc = acc + longint'($signed(w[k])) * wt;
		end
		// Bias rule (c - 3) * 2^20
		acc = acc + longint'(c - 3) * (longint'(1) << 20);
		// Accumulator is 32 bits wide
		acc_low = acc[fixp_pkg::ACC_W-1:0];
		// ReLU
		if (acc_low[fixp_pkg::ACC_W-1]) begin
			return '0;
		end
		// Slice with a zero on top
		return {1'b0, acc_low[fixp_pkg::OUT_MSB:fixp_pkg::FRAC_BITS]};
	endfunction

	////////////////////////////////////////
	// Port monitor and compare
	////////////////////////////////////////

	// Values seen here are the ones before the edge
	always @(posedge clk) begin
		cyc++;
		if (rst) begin
			tap_idx = 0;
			consumed = 0;
			samples = 0;
			done_seen = 1'b0;
			fb_seen = 1'b0;
			exp_fin = 1'b0;
			held_row = '0;
			exp_q.delete();
			end_cyc_q.delete();
		end else begin
			// Finish level against the model
			if (finish !== exp_fin) begin
				errs++;
				$display("ERROR: time %0t finish expected %b actual %b", $time, exp_fin, finish);
			end
			if (sample === 1'b1) begin
				samples++;
				if (exp_q.size() == 0) begin
					errs++;
					$display("Unexpected sample pulse at time %0t with no window pending", $time);
				end else begin
					exp_row = exp_q.pop_front();
					end_cyc = end_cyc_q.pop_front();
					// Five edges from the last tap
					if (cyc - end_cyc != 5) begin
						errs++;
						$display("ERROR: time %0t sample latency expected 5 actual %0d",
							$time, cyc - end_cyc);
					end
					for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
						if (ofm[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W] !==
							exp_row[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W]) begin
							errs++;
							$display("ERROR: time %0t ofm[%0d] expected %h actual %h", $time, c,
								exp_row[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W],
								ofm[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W]);
						end
					end
				end
				held_row = ofm;
				if (samples == conv_pkg::OUT_PIXELS) begin
					done_seen = 1'b1;
				end
			end else if (ofm !== held_row) begin
				// ofm must hold between pulses
				errs++;
				$display("ERROR: time %0t ofm expected %h actual %h", $time, held_row, ofm);
			end
			// Pixel intake, nothing past the last window
			if (en === 1'b1 && consumed < conv_pkg::TAPS * conv_pkg::OUT_PIXELS) begin
				win[tap_idx] = ifm;
				consumed++;
				tap_idx++;
				if (tap_idx == conv_pkg::TAPS) begin
					for (int c = 0; c < conv_pkg::CH_OUT; c++) begin
						exp_row[c*fixp_pkg::PIX_W +: fixp_pkg::PIX_W] = ref_channel(c, win);
					end
					exp_q.push_back(exp_row);
					end_cyc_q.push_back(cyc);
					tap_idx = 0;
				end
			end
			if (ram_feedback === 1'b1) begin
				fb_seen = 1'b1;
			end
			exp_fin = done_seen && !fb_seen;
		end
		err_cnt <= errs;
		sample_cnt <= samples;
	end

endmodule

// ==== bench/conv_layer_tb.sv ====
module conv_layer_tb;

	logic                                         clk;
	logic                                         rst;
	logic                                         en;
	logic [fixp_pkg::PIX_W-1:0]                   ifm;
	logic                                         ram_feedback;
	logic [conv_pkg::CH_OUT*fixp_pkg::PIX_W-1:0]  ofm;
	logic                                         sample;
	logic                                         finish;
	int                                           err_cnt;
	int                                           sample_cnt;

	logic [31:0] rnd_state;
	int          tb_errs;
	int          tests_run;
	int          tests_failed;
	int          test_start_errs;
	logic        timed_out;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	conv_layer u_conv_layer (
		.clk          (clk),
		.rst          (rst),
		.en           (en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.sample       (sample),
		.finish       (finish)
	);

	conv_layer_checker u_conv_layer_checker (
		.clk          (clk),
		.rst          (rst),
		.en           (en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.sample       (sample),
		.finish       (finish),
		.err_cnt      (err_cnt),
		.sample_cnt   (sample_cnt)
	);

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] r);
		rnd_state = xorshift32(rnd_state);
		r = rnd_state;
	endtask

	// Checker, bench and bound assertions together
	function automatic int total_errors();
		return err_cnt + tb_errs + u_conv_layer.u_tap_sequencer.u_conv_layer_properties.fail_cnt;
	endfunction

	// Kind 0 small random, 1 large positive, 2 large negative, 3 large random
	task automatic make_pixel(input int kind, output logic [fixp_pkg::PIX_W-1:0] p);
		logic [31:0] r;
		int v;
		draw_random(r);
		case (kind)
			1: v = 4000;
			2: v = -4000;
			3: v = int'(r % 8001) - 4000;
			default: v = int'($signed(r[7:0]));
		endcase
		p = v[fixp_pkg::PIX_W-1:0];
	endtask

	// Random idle cycles, then one pixel with en
	task automatic send_pixel(input logic [fixp_pkg::PIX_W-1:0] value, input int max_gap);
		logic [31:0] r;
		int gaps;
		gaps = 0;
		r = '0;
		if (max_gap > 0) begin
			draw_random(r);
			gaps = r % (max_gap + 1);
		end
		for (int i = 0; i < gaps; i++) begin
			@(posedge clk);
			en <= 1'b0;
			ifm <= r[31:16];
		end
		@(posedge clk);
		en <= 1'b1;
		ifm <= value;
	endtask

	task automatic send_window(input int kind, input int max_gap);
		logic [fixp_pkg::PIX_W-1:0] p;
		for (int k = 0; k < conv_pkg::TAPS; k++) begin
			make_pixel(kind, p);
			send_pixel(p, max_gap);
		end
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			en <= 1'b0;
		end
	endtask

	task automatic wait_for_samples(input int target, input int limit);
		int n;
		n = 0;
		while (sample_cnt < target && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (sample_cnt < target) begin
			$display("Timeout after %0d cycles waiting for sample pulse %0d, %0d seen",
				limit, target, sample_cnt);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_finish(input logic level, input int limit);
		int n;
		n = 0;
		while (finish !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (finish !== level) begin
			$display("Timeout after %0d cycles waiting for finish to become %b", limit, level);
			timed_out = 1'b1;
		end
	endtask

	// One report line per test
	task automatic close_test(input string name);
		int errs;
		idle(3);
		errs = total_errors() - test_start_errs;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s, %0d errors", tests_run, name,
			(errs == 0) ? "ok" : "failed", errs);
		test_start_errs = total_errors();
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic back_to_back_window();
		send_window(0, 0);
		idle(1);
		wait_for_samples(1, 100);
		close_test("continuous stream");
	endtask

	// Gaps inside windows and between them
	task automatic windows_with_gaps();
		for (int w = 0; w < 6; w++) begin
			send_window(0, 3);
		end
		idle(1);
		wait_for_samples(7, 100);
		close_test("enable gaps");
	endtask

	// Lanes split into clamped and sliced
	task automatic relu_and_slice();
		send_window(1, 0);
		send_window(2, 1);
		send_window(3, 2);
		idle(1);
		wait_for_samples(10, 100);
		close_test("relu and requantization");
	endtask

	task automatic end_of_layer();
		logic [fixp_pkg::PIX_W-1:0] p;
		for (int w = 0; w < 5; w++) begin
			send_window(0, 2);
		end
		// Last window runs straight into extra pixels
		send_window(0, 0);
		for (int i = 0; i < 40; i++) begin
			make_pixel(0, p);
			send_pixel(p, 0);
		end
		idle(1);
		wait_for_samples(conv_pkg::OUT_PIXELS, 100);
		if (!timed_out) begin
			wait_for_finish(1'b1, 20);
		end
		idle(20);
		if (sample_cnt != conv_pkg::OUT_PIXELS) begin
			tb_errs++;
			$display("ERROR: time %0t sample_cnt expected %0d actual %0d",
				$time, conv_pkg::OUT_PIXELS, sample_cnt);
		end
		close_test("layer end");
	endtask

	task automatic feedback_release();
		logic [31:0] r;
		// Finish holds with no feedback
		for (int i = 0; i < 30; i++) begin
			@(posedge clk);
			if (finish !== 1'b1) begin
				tb_errs++;
				$display("ERROR: time %0t finish expected 1 actual %b", $time, finish);
			end
		end
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		wait_for_finish(1'b0, 10);
		// Stays low through more feedback and pixels
		for (int i = 0; i < 30; i++) begin
			@(posedge clk);
			if (finish !== 1'b0) begin
				tb_errs++;
				$display("ERROR: time %0t finish expected 0 actual %b", $time, finish);
			end
			draw_random(r);
			en <= r[0];
			ifm <= r[31:16];
			ram_feedback <= (i == 10);
		end
		@(posedge clk);
		en <= 1'b0;
		ram_feedback <= 1'b0;
		close_test("ram feedback");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int errs;
		rst = 1'b1;
		en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		rnd_state = 32'd25;
		tb_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		idle(3);
		test_start_errs = total_errors();
		back_to_back_window();
		if (!timed_out) begin
			windows_with_gaps();
		end
		if (!timed_out) begin
			relu_and_slice();
		end
		if (!timed_out) begin
			end_of_layer();
		end
		if (!timed_out) begin
			feedback_release();
		end
		errs = total_errors();
		$display("Tests run %0d, failed %0d, errors %0d, sample pulses %0d",
			tests_run, tests_failed, errs, sample_cnt);
		if (timed_out || tests_failed != 0 || errs != 0) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/fixp_pkg.sv
hdl/conv_pkg.sv
hdl/weight_rom.sv
hdl/bias_table.sv
hdl/tap_sequencer.sv
hdl/mac_unit.sv
hdl/mac_array.sv
hdl/conv_layer.sv
bench/conv_layer_properties.sv
bench/conv_layer_checker.sv
bench/conv_layer_tb.sv
